/* hdl/i2s_dma_cfg.svh */
/*
 * Widths, register map and reset values of the I2S receiver register block.
 * Addresses are word addresses on the 10-bit Wishbone bus.
 * Every read of REG_FIFO_DAT pops the FIFO, so software reads it only when it wants data.
 */
`ifndef I2S_DMA_CFG_SVH
`define I2S_DMA_CFG_SVH

// bus and payload widths
`define I2S_ADR_W       10
`define I2S_DAT_W       32
`define DECI_DAT_W      16
`define DECI_LVL_W      9
`define ACSLIP_W        32
`define ACSLIP_TMR_W    16
`define IRQ_NUM         5

// ----------------------------------------------------------------------
// register address map
`define REG_I2S_EN      10'h0
`define REG_ACSLIP_RST  10'h1
`define REG_INTR_STS    10'h2
`define REG_INTR_EN     10'h3
`define REG_FIFO_STS    10'h4
`define REG_FIFO_DAT    10'h5
`define REG_ACSLIP      10'h6
`define REG_FIFO_RST    10'h7
`define REG_DMA_EN      10'h8
`define REG_DMA_STS     10'h9
`define REG_DMA_CNT     10'hA
`define REG_ACSLIP_TMR  10'hB
`define REG_FIR_CTRL    10'hC

// reset values
`define DMA_CNT_RST     4
`define ACSLIP_TMR_RST  'h1DF

// ----------------------------------------------------------------------
// bit positions, interrupt status and enable share one layout
`define IRQ_DMA_DONE    0
`define IRQ_DECI_DONE   1
`define IRQ_DAT_AVL     2
`define IRQ_I2S_DIS     3
`define IRQ_ACSLIP      4

`define I2S_EN_BIT      0
`define ACSLIP_EN_BIT   2
`define FIFO_EMPTY_BIT  14
`define FIFO_FULL_BIT   15
`define FIR_EN_BIT      0
`define FIR_INT_EN_BIT  1

// DMA status, low nibble only
`define DMA_BUSY_BIT    0
`define DMA_DONE_BIT    1
`define DMA_ACT_BIT     2
`define DMA_REQ_BIT     3

`endif

/* hdl/i2s_dma_pkg.sv */
/*
 * Packed struct types shared by the register block.
 * Field widths come from the config header.
 */
`include "i2s_dma_cfg.svh"

package i2s_dma_pkg;

	// ----------------------------------------------------------------------
	// wishbone request as seen by the slave
	typedef struct packed {
		logic [`I2S_ADR_W-1:0]   adr;
		logic                    cyc;
		logic                    stb;
		logic                    we;
		logic [`I2S_DAT_W/8-1:0] sel;
		logic [`I2S_DAT_W-1:0]   dat;
	} wb_req_t;

	// one strobe per writable register
	// already qualified by first cycle and byte lane 0
	typedef struct packed {
		logic i2s_en;
		logic acslip_rst;
		logic intr_sts;
		logic intr_en;
		logic fifo_rst;
		logic dma_en;
		logic dma_cnt;
		logic acslip_tmr;
		logic fir_ctrl;
	} reg_wr_t;

	// ----------------------------------------------------------------------
	// register file state needed for readback
	typedef struct packed {
		logic                      i2s_en;
		logic                      acslip_en;
		logic                      acslip_rst;
		logic                      flush;
		logic                      dma_en;
		logic [`DECI_LVL_W-1:0]    dma_cnt;
		logic [`ACSLIP_TMR_W-1:0]  tmr_period;
		logic                      fir_en;
		logic                      fir_int_en;
		logic [`IRQ_NUM-1:0]       irq_en;
		logic [`IRQ_NUM-1:0]       irq_sts;
		logic                      dma_start;
	} ctrl_state_t;

	// decimation FIFO side
	typedef struct packed {
		logic [`DECI_DAT_W-1:0] dat;
		logic                   full;
		logic                   empty;
		logic [`DECI_LVL_W-1:0] level;
	} fifo_in_t;

	// DMA controller side
	typedef struct packed {
		logic done;
		logic active;
		logic req;
		logic busy;
		logic clr;
	} dma_in_t;

endpackage

/* hdl/wb_access_ctrl.sv */
/*
 * Wishbone acknowledge, write decode and FIFO pop.
 * Registers ack one cycle after strobe, FIFO data ack after two cycles.
 * After an ack the next ack is at least three cycles later.
 */
`timescale 1ns/1ps
`include "i2s_dma_cfg.svh"

module wb_access_ctrl (
	input  logic                 WBs_CLK_i,
	input  logic                 WBs_RST_i,
	input  i2s_dma_pkg::wb_req_t req_i,
	input  logic                 fifo_empty_i,
	output logic                 WBs_ACK_o,
	output i2s_dma_pkg::reg_wr_t reg_wr_o,
	output logic                 fifo_pop_o
);

	logic ack_sig;
	logic ack_sig_r;
	logic acc_start;
	logic wr_ok;
	logic fifo_sel;

	// first cycle of an access, blocked while either ack stage is busy
	assign acc_start = req_i.cyc & req_i.stb & ~ack_sig & ~ack_sig_r;
	assign wr_ok     = acc_start & req_i.we & req_i.sel[0];
	assign fifo_sel  = req_i.cyc && (req_i.adr == `REG_FIFO_DAT);

	// ----------------------------------------------------------------------
	// ack pipeline
	always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i)
	begin
		if (WBs_RST_i)
		begin
			ack_sig   <= 1'b0;
			ack_sig_r <= 1'b0;
		end
		else
		begin
			ack_sig   <= acc_start;
			ack_sig_r <= ack_sig;
		end
	end

	// FIFO data uses the delayed copy so two pops fit in
	assign WBs_ACK_o = fifo_sel ? ack_sig_r : ack_sig;

	// pop in both cycles before the ack, never on an empty FIFO
	assign fifo_pop_o = fifo_sel & req_i.stb & ~req_i.we & ~ack_sig_r & ~fifo_empty_i;

	// ----------------------------------------------------------------------
	// write strobes
	assign reg_wr_o.i2s_en     = wr_ok && (req_i.adr == `REG_I2S_EN);
	assign reg_wr_o.acslip_rst = wr_ok && (req_i.adr == `REG_ACSLIP_RST);
	assign reg_wr_o.intr_sts   = wr_ok && (req_i.adr == `REG_INTR_STS);
	assign reg_wr_o.intr_en    = wr_ok && (req_i.adr == `REG_INTR_EN);
	assign reg_wr_o.fifo_rst   = wr_ok && (req_i.adr == `REG_FIFO_RST);
	assign reg_wr_o.dma_en     = wr_ok && (req_i.adr == `REG_DMA_EN);
	assign reg_wr_o.dma_cnt    = wr_ok && (req_i.adr == `REG_DMA_CNT);
	assign reg_wr_o.acslip_tmr = wr_ok && (req_i.adr == `REG_ACSLIP_TMR);
	assign reg_wr_o.fir_ctrl   = wr_ok && (req_i.adr == `REG_FIR_CTRL);

endmodule

/* hdl/ctrl_reg_file.sv */
/*
 * Control, enable and sticky interrupt status registers.
 * A hardware event beats a status write in the same cycle.
 * The ACSLIP counter reset comes out of reset active.
 */
`timescale 1ns/1ps
`include "i2s_dma_cfg.svh"

module ctrl_reg_file (
	input  logic                     WBs_CLK_i,
	input  logic                     WBs_RST_i,
	input  i2s_dma_pkg::reg_wr_t     reg_wr_i,
	input  logic [`I2S_DAT_W-1:0]    wr_dat_i,
	input  logic [`DECI_LVL_W-1:0]   fifo_level_i,
	input  i2s_dma_pkg::dma_in_t     dma_i,
	input  logic                     deci_done_i,
	input  logic                     i2s_dis_i,
	input  logic                     acslip_evt_i,
	output i2s_dma_pkg::ctrl_state_t state_o,
	output logic                     I2S_S_EN_o,
	output logic                     ACSLIP_EN_o,
	output logic                     ACSLIP_Reg_Rst_o,
	output logic                     DeciData_Rx_FIFO_Flush_o,
	output logic                     FIR_ena_o,
	output logic                     DMA_Start_o,
	output logic                     DMA_Done_IRQ_o,
	output logic                     Deci_Done_IRQ_o,
	output logic                     DeciData_Rx_FIFO_DAT_IRQ_o,
	output logic                     I2S_Dis_IRQ_o,
	output logic                     ACSLIP_timer_IRQ_o,
	output logic                     DMA_Done_IRQ_EN_o,
	output logic                     Deci_Done_IRQ_EN_o,
	output logic                     DeciData_Rx_DAT_AVL_IRQ_EN_o,
	output logic                     I2S_Dis_IRQ_EN_o,
	output logic                     ACSLIP_timer_IRQ_EN_o
);

	logic                     i2s_en;
	logic                     acslip_en;
	logic                     acslip_rst;
	logic                     flush;
	logic                     dma_en;
	logic [`DECI_LVL_W-1:0]   dma_cnt;
	logic [`ACSLIP_TMR_W-1:0] tmr_period;
	logic                     fir_en;
	logic                     fir_int_en;
	logic [`IRQ_NUM-1:0]      irq_en;
	logic [`IRQ_NUM-1:0]      irq_sts;
	logic                     dat_avl;

	// level reached the DMA count
	assign dat_avl = (fifo_level_i >= dma_cnt);

	// ----------------------------------------------------------------------
	// configuration registers
	always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i)
	begin
		if (WBs_RST_i)
		begin
			i2s_en     <= 1'b0;
			acslip_en  <= 1'b0;
			acslip_rst <= 1'b1;
			flush      <= 1'b0;
			dma_en     <= 1'b0;
			dma_cnt    <= `DECI_LVL_W'(`DMA_CNT_RST);
			tmr_period <= `ACSLIP_TMR_W'(`ACSLIP_TMR_RST);
			fir_en     <= 1'b0;
			fir_int_en <= 1'b0;
			irq_en     <= '0;
		end
		else
		begin
			// i2s disable drops the enable unless software writes it now
			if (reg_wr_i.i2s_en)
			begin
				i2s_en    <= wr_dat_i[`I2S_EN_BIT];
				acslip_en <= wr_dat_i[`ACSLIP_EN_BIT];
			end
			else if (i2s_dis_i)
				i2s_en <= 1'b0;

			if (reg_wr_i.acslip_rst)
				acslip_rst <= wr_dat_i[0];

			// single-cycle flush pulse
			flush <= reg_wr_i.fifo_rst & wr_dat_i[0];

			if (reg_wr_i.dma_en)
				dma_en <= wr_dat_i[0];
			else if (dma_i.clr)
				dma_en <= 1'b0;

			if (reg_wr_i.dma_cnt)
				dma_cnt <= wr_dat_i[`DECI_LVL_W-1:0];
			if (reg_wr_i.acslip_tmr)
				tmr_period <= wr_dat_i[`ACSLIP_TMR_W-1:0];
			if (reg_wr_i.fir_ctrl)
			begin
				fir_en     <= wr_dat_i[`FIR_EN_BIT];
				fir_int_en <= wr_dat_i[`FIR_INT_EN_BIT];
			end
			if (reg_wr_i.intr_en)
				irq_en <= wr_dat_i[`IRQ_NUM-1:0];
		end
	end

	// ----------------------------------------------------------------------
	// sticky status, event sets, write overwrites
	always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i)
	begin
		if (WBs_RST_i)
		begin
			irq_sts[`IRQ_DMA_DONE]  <= 1'b0;
			irq_sts[`IRQ_DECI_DONE] <= 1'b0;
			irq_sts[`IRQ_I2S_DIS]   <= 1'b0;
			irq_sts[`IRQ_ACSLIP]    <= 1'b0;
		end
		else
		begin
			if (dma_i.done)
				irq_sts[`IRQ_DMA_DONE] <= 1'b1;
			else if (reg_wr_i.intr_sts)
				irq_sts[`IRQ_DMA_DONE] <= wr_dat_i[`IRQ_DMA_DONE];
			if (deci_done_i)
				irq_sts[`IRQ_DECI_DONE] <= 1'b1;
			else if (reg_wr_i.intr_sts)
				irq_sts[`IRQ_DECI_DONE] <= wr_dat_i[`IRQ_DECI_DONE];
			if (i2s_dis_i)
				irq_sts[`IRQ_I2S_DIS] <= 1'b1;
			else if (reg_wr_i.intr_sts)
				irq_sts[`IRQ_I2S_DIS] <= wr_dat_i[`IRQ_I2S_DIS];
			if (acslip_evt_i)
				irq_sts[`IRQ_ACSLIP] <= 1'b1;
			else if (reg_wr_i.intr_sts)
				irq_sts[`IRQ_ACSLIP] <= wr_dat_i[`IRQ_ACSLIP];
		end
	end

	// data available is a live level, not sticky
	assign irq_sts[`IRQ_DAT_AVL] = dat_avl;

	// ----------------------------------------------------------------------
	// outputs
	assign DMA_Start_o                  = dat_avl & dma_en;
	assign I2S_S_EN_o                   = i2s_en;
	assign ACSLIP_EN_o                  = acslip_en;
	assign ACSLIP_Reg_Rst_o             = acslip_rst;
	assign DeciData_Rx_FIFO_Flush_o     = flush;
	assign FIR_ena_o                    = fir_en;
	assign DMA_Done_IRQ_o               = irq_sts[`IRQ_DMA_DONE];
	assign Deci_Done_IRQ_o              = irq_sts[`IRQ_DECI_DONE];
	assign DeciData_Rx_FIFO_DAT_IRQ_o   = irq_sts[`IRQ_DAT_AVL];
	assign I2S_Dis_IRQ_o                = irq_sts[`IRQ_I2S_DIS];
	assign ACSLIP_timer_IRQ_o           = irq_sts[`IRQ_ACSLIP];
	assign DMA_Done_IRQ_EN_o            = irq_en[`IRQ_DMA_DONE];
	assign Deci_Done_IRQ_EN_o           = irq_en[`IRQ_DECI_DONE];
	assign DeciData_Rx_DAT_AVL_IRQ_EN_o = irq_en[`IRQ_DAT_AVL];
	assign I2S_Dis_IRQ_EN_o             = irq_en[`IRQ_I2S_DIS];
	assign ACSLIP_timer_IRQ_EN_o        = irq_en[`IRQ_ACSLIP];

	assign state_o.i2s_en     = i2s_en;
	assign state_o.acslip_en  = acslip_en;
	assign state_o.acslip_rst = acslip_rst;
	assign state_o.flush      = flush;
	assign state_o.dma_en     = dma_en;
	assign state_o.dma_cnt    = dma_cnt;
	assign state_o.tmr_period = tmr_period;
	assign state_o.fir_en     = fir_en;
	assign state_o.fir_int_en = fir_int_en;
	assign state_o.irq_en     = irq_en;
	assign state_o.irq_sts    = irq_sts;
	assign state_o.dma_start  = DMA_Start_o;

endmodule

/* hdl/acslip_timer.sv */
/*
 * ACSLIP period timer on the reference clock.
 * period_i is quasi-static, change it only while cnt_rst_i is held.
 * Event latency into the bus clock varies with the clock ratio.
 */
`timescale 1ns/1ps
`include "i2s_dma_cfg.svh"

module acslip_timer (
	input  logic                     WBs_CLK_i,
	input  logic                     WBs_RST_i,
	input  logic                     sys_ref_clk_i,
	input  logic                     cnt_rst_i,
	input  logic [`ACSLIP_TMR_W-1:0] period_i,
	input  logic [`ACSLIP_W-1:0]     acslip_reg_i,
	output logic                     evt_o,
	output logic [`ACSLIP_W-1:0]     snapshot_o
);

	logic                     tmr_rst;
	logic [`ACSLIP_TMR_W-1:0] tmr_cnt;
	logic                     tmr_pulse;
	logic [2:0]               pulse_sync;

	// bus reset or software counter reset
	assign tmr_rst = WBs_RST_i | cnt_rst_i;

	// ----------------------------------------------------------------------
	// reference domain, one pulse every period+1 cycles
	always_ff @(posedge sys_ref_clk_i or posedge tmr_rst)
	begin
		if (tmr_rst)
		begin
			tmr_cnt   <= '0;
			tmr_pulse <= 1'b0;
		end
		else if (tmr_cnt == period_i)
		begin
			tmr_cnt   <= '0;
			tmr_pulse <= 1'b1;
		end
		else
		begin
			tmr_cnt   <= tmr_cnt + 1'b1;
			tmr_pulse <= 1'b0;
		end
	end

	// ----------------------------------------------------------------------
	// bus domain, two sync stages plus one for the edge
	always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i)
	begin
		if (WBs_RST_i)
			pulse_sync <= '0;
		else
			pulse_sync <= {pulse_sync[1:0], tmr_pulse};
	end

	assign evt_o = pulse_sync[1] & ~pulse_sync[2];

	// snapshot of the external register on each event
	always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i)
	begin
		if (WBs_RST_i)
			snapshot_o <= '0;
		else if (evt_o)
			snapshot_o <= acslip_reg_i;
	end

endmodule

/* hdl/wb_readback.sv */
/*
 * FIFO word pair and the read data mux.
 * Unmapped addresses read as zero.
 */
`timescale 1ns/1ps
`include "i2s_dma_cfg.svh"

module wb_readback (
	input  logic                     WBs_CLK_i,
	input  logic                     WBs_RST_i,
	input  logic [`I2S_ADR_W-1:0]    adr_i,
	input  i2s_dma_pkg::fifo_in_t    fifo_i,
	input  logic                     fifo_pop_i,
	input  i2s_dma_pkg::ctrl_state_t state_i,
	input  logic [`ACSLIP_W-1:0]     snapshot_i,
	input  i2s_dma_pkg::dma_in_t     dma_i,
	output logic [`I2S_DAT_W-1:0]    WBs_DAT_o
);

	logic [`DECI_DAT_W-1:0] pair_up;
	logic [`DECI_DAT_W-1:0] pair_lo;

	// each pop shifts the old upper word down, head goes up
	always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i)
	begin
		if (WBs_RST_i)
		begin
			pair_up <= '0;
			pair_lo <= '0;
		end
		else if (fifo_pop_i)
		begin
			pair_up <= fifo_i.dat;
			pair_lo <= pair_up;
		end
	end

	// ----------------------------------------------------------------------
	// read mux
	always_comb
	begin
		WBs_DAT_o = '0;
		case (adr_i)
			`REG_I2S_EN:
			begin
				WBs_DAT_o[`I2S_EN_BIT]    = state_i.i2s_en;
				WBs_DAT_o[`ACSLIP_EN_BIT] = state_i.acslip_en;
			end
			`REG_ACSLIP_RST: WBs_DAT_o[0] = state_i.acslip_rst;
			`REG_INTR_STS:   WBs_DAT_o[`IRQ_NUM-1:0] = state_i.irq_sts;
			`REG_INTR_EN:    WBs_DAT_o[`IRQ_NUM-1:0] = state_i.irq_en;
			`REG_FIFO_STS:
			begin
				WBs_DAT_o[`DECI_LVL_W-1:0] = fifo_i.level;
				WBs_DAT_o[`FIFO_EMPTY_BIT] = fifo_i.empty;
				WBs_DAT_o[`FIFO_FULL_BIT]  = fifo_i.full;
			end
			`REG_FIFO_DAT:   WBs_DAT_o = {pair_up, pair_lo};
			`REG_ACSLIP:     WBs_DAT_o = snapshot_i;
			`REG_FIFO_RST:   WBs_DAT_o[0] = state_i.flush;
			`REG_DMA_EN:     WBs_DAT_o[0] = state_i.dma_en;
			`REG_DMA_STS:
			begin
				// done bit is the sticky interrupt, the rest are live
				WBs_DAT_o[`DMA_BUSY_BIT] = dma_i.busy;
				WBs_DAT_o[`DMA_DONE_BIT] = state_i.irq_sts[`IRQ_DMA_DONE];
				WBs_DAT_o[`DMA_ACT_BIT]  = dma_i.active;
				WBs_DAT_o[`DMA_REQ_BIT]  = dma_i.req;
			end
			`REG_DMA_CNT:    WBs_DAT_o[`DECI_LVL_W-1:0] = state_i.dma_cnt;
			`REG_ACSLIP_TMR: WBs_DAT_o[`ACSLIP_TMR_W-1:0] = state_i.tmr_period;
			`REG_FIR_CTRL:
			begin
				WBs_DAT_o[`FIR_EN_BIT]     = state_i.fir_en;
				WBs_DAT_o[`FIR_INT_EN_BIT] = state_i.fir_int_en;
			end
			default:         WBs_DAT_o = '0;
		endcase
	end

endmodule

/* hdl/i2s_dma_regs_top.sv */
/*
 * Wishbone register block of the I2S slave receiver with DMA support.
 * Plain Wishbone classic cycles, no retry or error.
 */
`timescale 1ns/1ps
`include "i2s_dma_cfg.svh"

module i2s_dma_regs_top (
	input  logic                   WBs_CLK_i,
	input  logic                   WBs_RST_i,
	input  logic [`I2S_ADR_W-1:0]  WBs_ADR_i,
	input  logic                   WBs_CYC_i,
	input  logic [`I2S_DAT_W/8-1:0] WBs_BYTE_STB_i,
	input  logic                   WBs_WE_i,
	input  logic                   WBs_STB_i,
	input  logic [`I2S_DAT_W-1:0]  WBs_DAT_i,
	output logic [`I2S_DAT_W-1:0]  WBs_DAT_o,
	output logic                   WBs_ACK_o,
	input  logic                   sys_ref_clk_i,
	input  logic                   i2s_dis_i,
	input  logic [`ACSLIP_W-1:0]   ACLSIP_Reg_i,
	input  logic [`DECI_DAT_W-1:0] DeciData_Rx_FIFO_DAT_i,
	input  logic                   DeciData_Rx_FIFO_Full_i,
	input  logic                   DeciData_Rx_FIFO_Empty_i,
	input  logic [`DECI_LVL_W-1:0] DeciData_Rx_FIFO_Level_i,
	output logic                   DeciData_Rx_FIFO_Pop_o,
	input  logic                   FIR_DECI_Done_i,
	input  logic                   DMA_Busy_i,
	input  logic                   DMA_Clr_i,
	input  logic                   DMA_Done_i,
	input  logic                   DMA_Active_i,
	input  logic                   DMA_REQ_i,
	output logic [`DECI_LVL_W-1:0] DMA_CNT_o,
	output logic                   I2S_S_EN_o,
	output logic                   ACSLIP_EN_o,
	output logic                   ACSLIP_Reg_Rst_o,
	output logic                   DeciData_Rx_FIFO_Flush_o,
	output logic                   FIR_ena_o,
	output logic                   DMA_Start_o,
	output logic                   DMA_Done_IRQ_o,
	output logic                   Deci_Done_IRQ_o,
	output logic                   DeciData_Rx_FIFO_DAT_IRQ_o,
	output logic                   I2S_Dis_IRQ_o,
	output logic                   ACSLIP_timer_IRQ_o,
	output logic                   DMA_Done_IRQ_EN_o,
	output logic                   Deci_Done_IRQ_EN_o,
	output logic                   DeciData_Rx_DAT_AVL_IRQ_EN_o,
	output logic                   I2S_Dis_IRQ_EN_o,
	output logic                   ACSLIP_timer_IRQ_EN_o
);

	import i2s_dma_pkg::*;

	wb_req_t                wb_req;
	reg_wr_t                reg_wr;
	ctrl_state_t            ctrl_state;
	fifo_in_t               fifo_in;
	dma_in_t                dma_in;
	logic                   acslip_evt;
	logic [`ACSLIP_W-1:0]   acslip_snap;

	// ----------------------------------------------------------------------
	// bundle the pins
	assign wb_req  = '{adr: WBs_ADR_i, cyc: WBs_CYC_i, stb: WBs_STB_i, we: WBs_WE_i,
		sel: WBs_BYTE_STB_i, dat: WBs_DAT_i};
	assign fifo_in = '{dat: DeciData_Rx_FIFO_DAT_i, full: DeciData_Rx_FIFO_Full_i,
		empty: DeciData_Rx_FIFO_Empty_i, level: DeciData_Rx_FIFO_Level_i};
	assign dma_in  = '{done: DMA_Done_i, active: DMA_Active_i, req: DMA_REQ_i,
		busy: DMA_Busy_i, clr: DMA_Clr_i};

	assign DMA_CNT_o = ctrl_state.dma_cnt;

	// ----------------------------------------------------------------------
	// bus front end
	wb_access_ctrl u_access (
		.WBs_CLK_i    (WBs_CLK_i),
		.WBs_RST_i    (WBs_RST_i),
		.req_i        (wb_req),
		.fifo_empty_i (DeciData_Rx_FIFO_Empty_i),
		.WBs_ACK_o    (WBs_ACK_o),
		.reg_wr_o     (reg_wr),
		.fifo_pop_o   (DeciData_Rx_FIFO_Pop_o)
	);

	// register file, remaining outputs match top-level names
	ctrl_reg_file u_regs (
		.*,
		.reg_wr_i     (reg_wr),
		.wr_dat_i     (wb_req.dat),
		.fifo_level_i (DeciData_Rx_FIFO_Level_i),
		.dma_i        (dma_in),
		.deci_done_i  (FIR_DECI_Done_i),
		.acslip_evt_i (acslip_evt),
		.state_o      (ctrl_state)
	);

	acslip_timer u_acslip (
		.WBs_CLK_i     (WBs_CLK_i),
		.WBs_RST_i     (WBs_RST_i),
		.sys_ref_clk_i (sys_ref_clk_i),
		.cnt_rst_i     (ACSLIP_Reg_Rst_o),
		.period_i      (ctrl_state.tmr_period),
		.acslip_reg_i  (ACLSIP_Reg_i),
		.evt_o         (acslip_evt),
		.snapshot_o    (acslip_snap)
	);

	wb_readback u_rdback (
		.WBs_CLK_i  (WBs_CLK_i),
		.WBs_RST_i  (WBs_RST_i),
		.adr_i      (WBs_ADR_i),
		.fifo_i     (fifo_in),
		.fifo_pop_i (DeciData_Rx_FIFO_Pop_o),
		.state_i    (ctrl_state),
		.snapshot_i (acslip_snap),
		.dma_i      (dma_in),
		.WBs_DAT_o  (WBs_DAT_o)
	);

endmodule

/* verif/tb_i2s_dma_regs.sv */
/*
 * Testbench for the I2S register block, random stimulus with seed 33.
 * FIFO and DMA controller are simple behavioral models, FIFO depth 256.
 * ACSLIP latency is only bounded, the exact event cycle is not checked.
 */
`timescale 1ns/1ps
`include "i2s_dma_cfg.svh"

module tb_i2s_dma_regs;

	localparam int CLK_NS     = 4;
	localparam int FIFO_DEPTH = 256;
	localparam int ACK_LIMIT  = 8;
	localparam int N_RAND     = 60;
	localparam int N_EVT      = 24;
	localparam int N_DMA      = 12;
	localparam int N_FIFO     = 8;
	localparam int N_POLL     = 100;
	localparam int N_FLUSH    = 8;
	// rough cycle budget per test, then a margin of three
	localparam int TEST_CYCLES = 80 + N_RAND * 8 + N_EVT * 30 + N_DMA * 20 + N_FIFO * 5
		+ N_POLL * 4 + N_FLUSH * 4;
	localparam int WATCHDOG_NS = TEST_CYCLES * CLK_NS * 3;

	logic        WBs_CLK_i, WBs_RST_i, WBs_CYC_i, WBs_WE_i, WBs_STB_i, WBs_ACK_o;
	logic [9:0]  WBs_ADR_i;
	logic [3:0]  WBs_BYTE_STB_i;
	logic [31:0] WBs_DAT_i, WBs_DAT_o, ACLSIP_Reg_i;
	logic        sys_ref_clk_i, i2s_dis_i, FIR_DECI_Done_i;
	logic [15:0] DeciData_Rx_FIFO_DAT_i;
	logic        DeciData_Rx_FIFO_Full_i, DeciData_Rx_FIFO_Empty_i, DeciData_Rx_FIFO_Pop_o;
	logic [8:0]  DeciData_Rx_FIFO_Level_i, DMA_CNT_o;
	logic        DMA_Busy_i, DMA_Clr_i, DMA_Done_i, DMA_Active_i, DMA_REQ_i;
	logic        I2S_S_EN_o, ACSLIP_EN_o, ACSLIP_Reg_Rst_o, DeciData_Rx_FIFO_Flush_o;
	logic        FIR_ena_o, DMA_Start_o, DMA_Done_IRQ_o, Deci_Done_IRQ_o;
	logic        DeciData_Rx_FIFO_DAT_IRQ_o, I2S_Dis_IRQ_o, ACSLIP_timer_IRQ_o;
	logic        DMA_Done_IRQ_EN_o, Deci_Done_IRQ_EN_o, DeciData_Rx_DAT_AVL_IRQ_EN_o;
	logic        I2S_Dis_IRQ_EN_o, ACSLIP_timer_IRQ_EN_o;

	// reference register model, bit 2 of m_sts unused (live level)
	logic        m_i2s_en, m_acslip_en, m_acslip_rst, m_dma_en;
	logic [8:0]  m_dma_cnt;
	logic [15:0] m_tmr;
	logic [1:0]  m_fir;
	logic [4:0]  m_irq_en, m_sts;
	logic [31:0] m_snap;

	logic [15:0] fifo_q[$];
	logic [15:0] junk_word;
	logic        pop_seen;
	int          flush_cnt, checks_done;
	int          i, k, lat, flush_exp, seed;
	logic [9:0]  adr;
	logic [31:0] rd, d, last_pair;
	logic [3:0]  sel;
	logic        seen;

	i2s_dma_regs_top u_dut (.*);

	initial WBs_CLK_i = 1'b0;
	always #(CLK_NS / 2) WBs_CLK_i = ~WBs_CLK_i;
	initial sys_ref_clk_i = 1'b0;
	always #5 sys_ref_clk_i = ~sys_ref_clk_i;

	// ----------------------------------------------------------------------
	// FIFO model, pop seen at negedge, queue and pins move after the edge
	always @(negedge WBs_CLK_i) pop_seen <= DeciData_Rx_FIFO_Pop_o;
	always @(negedge WBs_CLK_i) if (DeciData_Rx_FIFO_Flush_o) flush_cnt++;

	always @(posedge WBs_CLK_i)
	begin
		#1;
		if (pop_seen)
		begin
			if (fifo_q.size() == 0)
				abort_run("DUT popped the FIFO while it was empty");
			else
				junk_word = fifo_q.pop_front();
		end
		DeciData_Rx_FIFO_DAT_i   = (fifo_q.size() > 0) ? fifo_q[0] : 16'h0;
		DeciData_Rx_FIFO_Empty_i = (fifo_q.size() == 0);
		DeciData_Rx_FIFO_Full_i  = (fifo_q.size() >= FIFO_DEPTH);
		DeciData_Rx_FIFO_Level_i = 9'(fifo_q.size());
	end

	initial
	begin
		#(WATCHDOG_NS);
		abort_run("watchdog expired, the run took far longer than its tests need");
	end

	// ----------------------------------------------------------------------
	// reporting and model helpers
	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Finished with errors");
		$fatal(1, "run stopped");
	endtask

	task automatic check_value(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		checks_done++;
		if (exp !== act)
			abort_run($sformatf("FAILED %s: expected %h, actual %h", name, exp, act));
	endtask

	// level at least count
	function automatic logic data_avail();
		return 9'(fifo_q.size()) >= m_dma_cnt;
	endfunction

	function automatic logic [31:0] exp_reg(input logic [9:0] a);
		logic [31:0] v;
		logic [8:0]  lvl;
		lvl = 9'(fifo_q.size());
		case (a)
			`REG_I2S_EN:     v = {29'd0, m_acslip_en, 1'b0, m_i2s_en};
			`REG_ACSLIP_RST: v = {31'd0, m_acslip_rst};
			`REG_INTR_STS:   v = {27'd0, m_sts[4:3], data_avail(), m_sts[1:0]};
			`REG_INTR_EN:    v = {27'd0, m_irq_en};
			`REG_FIFO_STS:   v = {16'd0, fifo_q.size() >= FIFO_DEPTH, fifo_q.size() == 0,
				5'd0, lvl};
			`REG_ACSLIP:     v = m_snap;
			`REG_DMA_EN:     v = {31'd0, m_dma_en};
			`REG_DMA_STS:    v = {28'd0, DMA_REQ_i, DMA_Active_i, m_sts[0], DMA_Busy_i};
			`REG_DMA_CNT:    v = {23'd0, m_dma_cnt};
			`REG_ACSLIP_TMR: v = {16'd0, m_tmr};
			`REG_FIR_CTRL:   v = {30'd0, m_fir};
			// flush is a pulse, idle reads give zero like unmapped space
			default:         v = '0;
		endcase
		return v;
	endfunction

	// ----------------------------------------------------------------------
	// bus side
	task automatic bus_access(input logic [9:0] a, input logic we, input logic [3:0] s,
		input logic [31:0] wdat, output logic [31:0] rdat, output int cycles);
		int waited;
		@(posedge WBs_CLK_i);
		#1;
		WBs_ADR_i      = a;
		WBs_WE_i       = we;
		WBs_BYTE_STB_i = s;
		WBs_DAT_i      = wdat;
		WBs_CYC_i      = 1'b1;
		WBs_STB_i      = 1'b1;
		waited         = 0;
		do
		begin
			@(negedge WBs_CLK_i);
			waited++;
			if (waited > ACK_LIMIT)
				abort_run("no bus acknowledge arrived for an access");
		end
		while (!WBs_ACK_o);
		rdat   = WBs_DAT_o;
		// first negedge lies in the strobe cycle itself
		cycles = waited - 1;
		@(posedge WBs_CLK_i);
		#1;
		WBs_CYC_i = 1'b0;
		WBs_STB_i = 1'b0;
		WBs_WE_i  = 1'b0;
	endtask

	task automatic write_reg(input logic [9:0] a, input logic [31:0] wd, input logic [3:0] s);
		logic [31:0] rdat;
		int          cyc;
		bus_access(a, 1'b1, s, wd, rdat, cyc);
		check_value("write ack latency", 1, 32'(cyc));
		// lane 0 missing means the write is ignored
		if (s[0])
		begin
			case (a)
				`REG_I2S_EN:
				begin
					m_i2s_en    = wd[0];
					m_acslip_en = wd[2];
				end
				`REG_ACSLIP_RST: m_acslip_rst = wd[0];
				`REG_INTR_STS:   m_sts = wd[4:0];
				`REG_INTR_EN:    m_irq_en = wd[4:0];
				`REG_DMA_EN:     m_dma_en = wd[0];
				`REG_DMA_CNT:    m_dma_cnt = wd[8:0];
				`REG_ACSLIP_TMR: m_tmr = wd[15:0];
				`REG_FIR_CTRL:   m_fir = wd[1:0];
				default:         m_fir = m_fir;
			endcase
		end
	endtask

	task automatic read_check(input string name, input logic [9:0] a);
		logic [31:0] rdat;
		int          cyc;
		bus_access(a, 1'b0, 4'hF, 32'h0, rdat, cyc);
		check_value({name, " ack latency"}, 1, 32'(cyc));
		check_value($sformatf("%s addr %h", name, a), exp_reg(a), rdat);
	endtask

	task automatic fifo_read_check(input logic [31:0] exp_pair, input int exp_size);
		logic [31:0] rdat;
		int          cyc;
		bus_access(`REG_FIFO_DAT, 1'b0, 4'hF, 32'h0, rdat, cyc);
		check_value("fifo read ack latency", 2, 32'(cyc));
		check_value("fifo word pair", exp_pair, rdat);
		check_value("fifo model size", 32'(exp_size), 32'(fifo_q.size()));
	endtask

	// all level outputs against the model
	task automatic check_pins();
		@(negedge WBs_CLK_i);
		check_value("irq status pins", 32'({m_sts[4:3], data_avail(), m_sts[1:0]}),
			32'({ACSLIP_timer_IRQ_o, I2S_Dis_IRQ_o, DeciData_Rx_FIFO_DAT_IRQ_o,
			Deci_Done_IRQ_o, DMA_Done_IRQ_o}));
		check_value("irq enable pins", 32'(m_irq_en), 32'({ACSLIP_timer_IRQ_EN_o,
			I2S_Dis_IRQ_EN_o, DeciData_Rx_DAT_AVL_IRQ_EN_o, Deci_Done_IRQ_EN_o,
			DMA_Done_IRQ_EN_o}));
		check_value("control pins", 32'({m_i2s_en, m_acslip_en, m_acslip_rst, m_fir[0], 2'b00}),
			32'({I2S_S_EN_o, ACSLIP_EN_o, ACSLIP_Reg_Rst_o, FIR_ena_o,
			DeciData_Rx_FIFO_Flush_o, DeciData_Rx_FIFO_Pop_o}));
		check_value("dma start pin", 32'(m_dma_en & data_avail()), 32'(DMA_Start_o));
		check_value("dma count pin", 32'(m_dma_cnt), 32'(DMA_CNT_o));
	endtask

	// ----------------------------------------------------------------------
	// stimulus helpers
	task automatic fill_fifo(input int n);
		@(posedge WBs_CLK_i);
		#1;
		fifo_q.delete();
		repeat (n) fifo_q.push_back(16'($urandom));
		repeat (2) @(posedge WBs_CLK_i);
	endtask

	task automatic pulse_event(input int which);
		@(posedge WBs_CLK_i);
		#1;
		case (which)
			0:       DMA_Done_i = 1'b1;
			1:       FIR_DECI_Done_i = 1'b1;
			2:       i2s_dis_i = 1'b1;
			default: DMA_Clr_i = 1'b1;
		endcase
		@(posedge WBs_CLK_i);
		#1;
		{DMA_Done_i, FIR_DECI_Done_i, i2s_dis_i, DMA_Clr_i} = 4'b0;
	endtask

	task automatic set_dma_levels();
		@(posedge WBs_CLK_i);
		#1;
		{DMA_Busy_i, DMA_Active_i, DMA_REQ_i} = 3'($urandom);
	endtask

	function automatic logic [9:0] pick_wr_addr(input int idx);
		case (idx)
			0:       return `REG_I2S_EN;
			1:       return `REG_INTR_EN;
			2:       return `REG_DMA_EN;
			3:       return `REG_DMA_CNT;
			4:       return `REG_ACSLIP_TMR;
			default: return `REG_FIR_CTRL;
		endcase
	endfunction

	// ----------------------------------------------------------------------
	// main sequence
	initial
	begin
		seed = $urandom(33);
		WBs_RST_i = 1'b1;
		{WBs_CYC_i, WBs_STB_i, WBs_WE_i} = 3'b0;
		WBs_ADR_i = '0;
		WBs_BYTE_STB_i = '0;
		WBs_DAT_i = '0;
		ACLSIP_Reg_i = '0;
		{i2s_dis_i, FIR_DECI_Done_i, DMA_Busy_i, DMA_Clr_i, DMA_Done_i} = 5'b0;
		{DMA_Active_i, DMA_REQ_i} = 2'b0;
		DeciData_Rx_FIFO_DAT_i = '0;
		{DeciData_Rx_FIFO_Full_i, DeciData_Rx_FIFO_Empty_i} = 2'b01;
		DeciData_Rx_FIFO_Level_i = '0;
		pop_seen = 1'b0;
		flush_cnt = 0;
		checks_done = 0;
		{m_i2s_en, m_acslip_en, m_acslip_rst, m_dma_en} = 4'b0010;
		m_dma_cnt = 9'(`DMA_CNT_RST);
		m_tmr = 16'(`ACSLIP_TMR_RST);
		m_fir = '0;
		m_irq_en = '0;
		m_sts = '0;
		m_snap = '0;
		repeat (10) @(posedge WBs_CLK_i);
		#1 WBs_RST_i = 1'b0;

		// reset values
		check_pins();
		for (i = 0; i <= 12; i++)
			if (i != 5) read_check("reset value", 10'(i));

		// random writes and reads, lane 0 gates every write
		set_dma_levels();
		for (i = 0; i < N_RAND; i++)
		begin
			adr = pick_wr_addr($urandom % 6);
			sel = 4'($urandom);
			write_reg(adr, $urandom, sel);
			read_check("readback", adr);
			adr = 10'($urandom % 16);
			if (adr == `REG_FIFO_DAT)
				adr = 10'h200 | 10'($urandom % 512);
			read_check("random read", adr);
		end
		check_pins();

		// hardware events and sticky status
		for (i = 0; i < N_EVT; i++)
		begin
			set_dma_levels();
			write_reg(`REG_I2S_EN, {29'd0, 1'($urandom), 2'b01}, 4'hF);
			write_reg(`REG_DMA_EN, 32'h1, 4'hF);
			k = $urandom % 4;
			pulse_event(k);
			case (k)
				0: m_sts[0] = 1'b1;
				1: m_sts[1] = 1'b1;
				2:
				begin
					m_sts[3] = 1'b1;
					m_i2s_en = 1'b0;
				end
				default: m_dma_en = 1'b0;
			endcase
			check_pins();
			read_check("event status", `REG_INTR_STS);
			read_check("event i2s enable", `REG_I2S_EN);
			read_check("event dma enable", `REG_DMA_EN);
			read_check("event dma status", `REG_DMA_STS);
			if ($urandom % 3 == 0)
			begin
				write_reg(`REG_INTR_STS, $urandom, 4'hF);
				read_check("status overwrite", `REG_INTR_STS);
			end
		end
		write_reg(`REG_INTR_STS, 32'h0, 4'hF);
		read_check("status cleared", `REG_INTR_STS);

		// DMA start request against level and count
		for (i = 0; i < N_DMA; i++)
		begin
			fill_fifo($urandom % 32);
			write_reg(`REG_DMA_CNT, $urandom % 32, 4'hF);
			write_reg(`REG_DMA_EN, $urandom % 2, 4'hF);
			check_pins();
			read_check("dma start status", `REG_INTR_STS);
			read_check("fifo status", `REG_FIFO_STS);
		end

		// FIFO data, second word read lands in the upper half
		fill_fifo(2 * N_FIFO);
		for (i = 0; i < N_FIFO; i++)
		begin
			last_pair = {fifo_q[1], fifo_q[0]};
			fifo_read_check(last_pair, fifo_q.size() - 2);
		end
		// empty FIFO, pair register holds
		fifo_read_check(last_pair, 0);
		check_pins();

		// ACSLIP timer with a short period
		@(posedge WBs_CLK_i);
		#1 ACLSIP_Reg_i = $urandom;
		write_reg(`REG_ACSLIP_TMR, 2 + ($urandom % 8), 4'hF);
		write_reg(`REG_ACSLIP_RST, 32'h0, 4'hF);
		read_check("acslip reset off", `REG_ACSLIP_RST);
		seen = 1'b0;
		for (i = 0; i < N_POLL && !seen; i++)
		begin
			bus_access(`REG_INTR_STS, 1'b0, 4'hF, 32'h0, rd, lat);
			check_value("status poll ack latency", 1, 32'(lat));
			seen = rd[`IRQ_ACSLIP];
		end
		if (!seen)
			abort_run("ACSLIP status bit did not set within the polling limit");
		m_snap = ACLSIP_Reg_i;
		read_check("acslip snapshot", `REG_ACSLIP);
		// stop the timer, let the synchronizer drain
		write_reg(`REG_ACSLIP_RST, 32'h1, 4'hF);
		repeat (10) @(posedge WBs_CLK_i);
		// new external value must not reach the snapshot without an event
		#1 ACLSIP_Reg_i = ~m_snap;
		write_reg(`REG_INTR_STS, 32'h0, 4'hF);
		read_check("acslip status cleared", `REG_INTR_STS);
		read_check("acslip snapshot held", `REG_ACSLIP);
		check_pins();

		// flush pulses
		flush_cnt = 0;
		flush_exp = 0;
		for (i = 0; i < N_FLUSH; i++)
		begin
			d = $urandom;
			sel = 4'($urandom);
			write_reg(`REG_FIFO_RST, d, sel);
			if (sel[0] && d[0])
				flush_exp++;
			read_check("flush readback", `REG_FIFO_RST);
		end
		check_value("flush pulse count", 32'(flush_exp), 32'(flush_cnt));
		check_pins();

		if (checks_done > 0)
		begin
			$display("Finished with no errors");
			$finish;
		end
		else
			abort_run("no checks were run");
	end

endmodule

/* verilog.f */
+incdir+hdl
hdl/i2s_dma_pkg.sv
hdl/wb_access_ctrl.sv
hdl/ctrl_reg_file.sv
hdl/acslip_timer.sv
hdl/wb_readback.sv
hdl/i2s_dma_regs_top.sv
verif/tb_i2s_dma_regs.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the register block testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
	-f verilog.f \
	--top-module tb_i2s_dma_regs \
	--Mdir obj_dir -o tb_sim

status=0
./obj_dir/tb_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -qx "Finished with no errors" sim.log; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed, exit status ${status}, see sim.log"
	exit 1
fi
